// File: Makefile
TB_TOP = leaf_i3o6_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f leaf_i3o6.f --top-module leaf_i3o6

sim:
	verilator --binary --timing --assert -f leaf_i3o6.f --top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "Test completed successfully" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// File: leaf_i3o6.f
logic/noc_pkg.sv
logic/leaf_pkg.sv
logic/leaf_stream_fifo.sv
logic/leaf_rx_depacketizer.sv
logic/mirror_kernel.sv
logic/leaf_tx_packetizer.sv
logic/leaf_i3o6.sv
verif/leaf_i3o6_tb.sv

// File: logic/leaf_i3o6.sv
`default_nettype none
`timescale 1ns/10ps

module leaf_i3o6 #(
    parameter int LEAF_ID    = 5,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk_400,
    input  logic                 reset,
    input  logic                 resend,
    input  noc_pkg::noc_packet_t din_leaf_bft2interface,
    output noc_pkg::noc_packet_t dout_leaf_interface2bft
);
    import leaf_pkg::*;

    route_wr_t route_wr;
    stream_t   in_streams [NUM_IN_PORTS];
    logic      in_acks [NUM_IN_PORTS];
    stream_t   out_streams [NUM_OUT_PORTS];
    logic      out_acks [NUM_OUT_PORTS];

    // input side
    leaf_rx_depacketizer #(
        .LEAF_ID   (LEAF_ID),
        .FIFO_DEPTH(FIFO_DEPTH)
    ) rx_i (
        .clk_400   (clk_400),
        .reset     (reset),
        .din       (din_leaf_bft2interface),
        .route_wr  (route_wr),
        .in_streams(in_streams),
        .in_acks   (in_acks)
    );

    mirror_kernel kernel_i (
        .clk_400    (clk_400),
        .reset      (reset),
        .in_streams (in_streams),
        .in_acks    (in_acks),
        .out_streams(out_streams),
        .out_acks   (out_acks)
    );

    // output side
    leaf_tx_packetizer tx_i (
        .clk_400    (clk_400),
        .reset      (reset),
        .resend     (resend),
        .route_wr   (route_wr),
        .out_streams(out_streams),
        .out_acks   (out_acks),
        .dout       (dout_leaf_interface2bft)
    );

endmodule

`default_nettype wire

// File: logic/leaf_pkg.sv
`default_nettype none

package leaf_pkg;

    localparam int NUM_IN_PORTS = 3;
    localparam int NUM_OUT_PORTS = 6;

    // wide enough for output ports 1 to 6
    localparam int OUT_PORT_BITS = 3;

    localparam int RESERVED_BITS = noc_pkg::PAYLOAD_BITS - OUT_PORT_BITS
                                   - noc_pkg::LEAF_BITS - noc_pkg::PORT_BITS;

    // producer side of a stream, ack runs back on its own wire
    typedef struct packed {
        logic                             vld;
        logic [noc_pkg::PAYLOAD_BITS-1:0] data;
    } stream_t;

    // route table entry as carried in a config payload
    typedef struct packed {
        logic [OUT_PORT_BITS-1:0]      out_port;
        logic [noc_pkg::LEAF_BITS-1:0] dest_leaf;
        logic [noc_pkg::PORT_BITS-1:0] dest_port;
        logic [RESERVED_BITS-1:0]      reserved;
    } route_cfg_t;

    // one payload, two readings depending on dest_port
    typedef union packed {
        logic [noc_pkg::PAYLOAD_BITS-1:0] word;
        route_cfg_t                       cfg;
    } payload_u;

    // table write from rx to tx
    typedef struct packed {
        logic       en;
        route_cfg_t cfg;
    } route_wr_t;

endpackage

`default_nettype wire

// File: logic/leaf_rx_depacketizer.sv
`default_nettype none
`timescale 1ns/10ps

module leaf_rx_depacketizer #(
    parameter int LEAF_ID    = 5,
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk_400,
    input  logic                 reset,
    input  noc_pkg::noc_packet_t din,
    output leaf_pkg::route_wr_t  route_wr,
    output leaf_pkg::stream_t    in_streams [leaf_pkg::NUM_IN_PORTS],
    input  logic                 in_acks [leaf_pkg::NUM_IN_PORTS]
);
    import noc_pkg::*;
    import leaf_pkg::*;

    noc_packet_t pkt_q;
    logic        pkt_vld;
    payload_u    pl;
    logic        cfg_hit;
    logic        push_req [NUM_IN_PORTS];
    logic        full [NUM_IN_PORTS];

    // payload held without reset, only the valid flag is cleared
    always_ff @(posedge clk_400) begin
        pkt_q <= din;
    end

    // drop anything for other leaves right at the input
    always_ff @(posedge clk_400) begin
        if (reset) begin
            pkt_vld <= 1'b0;
        end else begin
            pkt_vld <= din.vld && (din.dest_leaf == LEAF_BITS'(LEAF_ID));
        end
    end

    assign pl.word = pkt_q.payload;
    assign cfg_hit = pkt_vld && (pkt_q.dest_port == CFG_PORT);

    // table write one cycle behind the decode
    always_ff @(posedge clk_400) begin
        if (reset) begin
            route_wr.en <= 1'b0;
        end else begin
            route_wr.en <= cfg_hit;
        end
    end

    always_ff @(posedge clk_400) begin
        if (cfg_hit) begin
            route_wr.cfg <= pl.cfg;
        end
    end

    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_in
        // ports 1..3 map onto fifos 0..2, higher ports fall through
        assign push_req[i] = pkt_vld && (pkt_q.dest_port == PORT_BITS'(i + 1));

        leaf_stream_fifo #(
            .FIFO_DEPTH(FIFO_DEPTH)
        ) fifo_i (
            .clk_400   (clk_400),
            .reset     (reset),
            .push      (push_req[i]),
            .push_data (pl.word),
            .full      (full[i]),
            .out_stream(in_streams[i]),
            .out_ack   (in_acks[i])
        );

        // the network cannot stall, so a full fifo loses the word
        assert property (@(posedge clk_400) disable iff (reset) push_req[i] |-> !full[i])
            else $error("input port %0d overflow, packet dropped", i + 1);
    end

endmodule

`default_nettype wire

// File: logic/leaf_stream_fifo.sv
`default_nettype none
`timescale 1ns/10ps

module leaf_stream_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                             clk_400,
    input  logic                             reset,
    input  logic                             push,
    input  logic [noc_pkg::PAYLOAD_BITS-1:0] push_data,
    output logic                             full,
    output leaf_pkg::stream_t                out_stream,
    input  logic                             out_ack
);
    import noc_pkg::*;

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]     wr_ptr;
    logic [PTR_BITS-1:0]     rd_ptr;
    logic [CNT_BITS-1:0]     count;
    logic                    wr_en;
    logic                    rd_en;

    assign full = (count == CNT_BITS'(FIFO_DEPTH));
    assign wr_en = push && !full;
    assign rd_en = out_stream.vld && out_ack;

    // head word is shown as soon as it is written
    assign out_stream.vld = (count != '0);
    assign out_stream.data = mem[rd_ptr];

    always_ff @(posedge clk_400) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk_400) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en) begin
                count <= count + 1'b1;
            end else if (rd_en && !wr_en) begin
                count <= count - 1'b1;
            end
        end
    end

    // upstream must drop its own overflow
    assert property (@(posedge clk_400) disable iff (reset) full |-> !push)
        else $error("push into full fifo");

    // consumer acks only a presented word
    assert property (@(posedge clk_400) disable iff (reset) out_ack |-> out_stream.vld)
        else $error("ack without valid");

endmodule

`default_nettype wire

// File: logic/leaf_tx_packetizer.sv
`default_nettype none
`timescale 1ns/10ps

module leaf_tx_packetizer (
    input  logic                 clk_400,
    input  logic                 reset,
    input  logic                 resend,
    input  leaf_pkg::route_wr_t  route_wr,
    input  leaf_pkg::stream_t    out_streams [leaf_pkg::NUM_OUT_PORTS],
    output logic                 out_acks [leaf_pkg::NUM_OUT_PORTS],
    output noc_pkg::noc_packet_t dout
);
    import noc_pkg::*;
    import leaf_pkg::*;

    route_cfg_t               route_table [NUM_OUT_PORTS];
    logic [OUT_PORT_BITS-1:0] wr_idx;
    logic                     wr_ok;
    logic [OUT_PORT_BITS-1:0] last_grant;
    logic [OUT_PORT_BITS-1:0] grant_idx;
    logic                     found;
    logic                     grant;
    logic [NUM_OUT_PORTS-1:0] ack_vec;
    noc_packet_t              pkt_next;
    noc_packet_t              dout_q;

    // out_port 0 and 7 name no stream
    assign wr_ok = route_wr.en && (route_wr.cfg.out_port != '0)
                   && (route_wr.cfg.out_port <= OUT_PORT_BITS'(NUM_OUT_PORTS));
    assign wr_idx = route_wr.cfg.out_port - OUT_PORT_BITS'(1);

    always_ff @(posedge clk_400) begin
        if (reset) begin
            for (int k = 0; k < NUM_OUT_PORTS; k++) begin
                route_table[k] <= '0;
            end
        end else if (wr_ok) begin
            route_table[wr_idx] <= route_wr.cfg;
        end
    end

    // round robin, search starts just after the last grant
    always_comb begin
        int idx;
        found = 1'b0;
        grant_idx = '0;
        for (int k = 1; k <= NUM_OUT_PORTS; k++) begin
            idx = int'(last_grant) + k;
            if (idx >= NUM_OUT_PORTS) begin
                idx = idx - NUM_OUT_PORTS;
            end
            if (!found && out_streams[idx].vld) begin
                found = 1'b1;
                grant_idx = OUT_PORT_BITS'(idx);
            end
        end
    end

    assign grant = found && !resend;

    for (genvar j = 0; j < NUM_OUT_PORTS; j++) begin : g_ack
        assign ack_vec[j] = grant && (grant_idx == OUT_PORT_BITS'(j));
        assign out_acks[j] = ack_vec[j];
    end

    always_comb begin
        pkt_next.vld = 1'b1;
        pkt_next.dest_leaf = route_table[grant_idx].dest_leaf;
        pkt_next.dest_port = route_table[grant_idx].dest_port;
        pkt_next.addr = ADDR_BITS'(grant_idx) + ADDR_BITS'(1);
        pkt_next.payload = out_streams[grant_idx].data;
    end

    always_ff @(posedge clk_400) begin
        if (reset) begin
            last_grant <= OUT_PORT_BITS'(NUM_OUT_PORTS - 1);
        end else if (grant) begin
            last_grant <= grant_idx;
        end
    end

    // a packet caught by resend is held and shown once it drops
    always_ff @(posedge clk_400) begin
        if (reset) begin
            dout_q <= '0;
        end else if (!resend) begin
            dout_q <= grant ? pkt_next : '0;
        end
    end

    assign dout = resend ? '0 : dout_q;

    assert property (@(posedge clk_400) disable iff (reset)
                     $onehot0(ack_vec) && (resend -> ack_vec == '0))
        else $error("bad ack pattern on output streams");

endmodule

`default_nettype wire

// File: logic/mirror_kernel.sv
`default_nettype none
`timescale 1ns/10ps

module mirror_kernel (
    input  logic              clk_400,
    input  logic              reset,
    input  leaf_pkg::stream_t in_streams [leaf_pkg::NUM_IN_PORTS],
    output logic              in_acks [leaf_pkg::NUM_IN_PORTS],
    output leaf_pkg::stream_t out_streams [leaf_pkg::NUM_OUT_PORTS],
    input  logic              out_acks [leaf_pkg::NUM_OUT_PORTS]
);
    import noc_pkg::*;
    import leaf_pkg::*;

    logic                    out_vld [NUM_OUT_PORTS];
    logic [PAYLOAD_BITS-1:0] out_data [NUM_OUT_PORTS];
    logic                    can_load [NUM_OUT_PORTS];
    logic                    take [NUM_IN_PORTS];

    // output register free now or freed by this cycle's ack
    for (genvar j = 0; j < NUM_OUT_PORTS; j++) begin : g_free
        assign can_load[j] = !out_vld[j] || out_acks[j];
    end

    // input i owns outputs 2i and 2i+1
    for (genvar i = 0; i < NUM_IN_PORTS; i++) begin : g_take
        assign take[i] = in_streams[i].vld && can_load[2*i] && can_load[2*i+1];
        assign in_acks[i] = take[i];
    end

    for (genvar j = 0; j < NUM_OUT_PORTS; j++) begin : g_out
        localparam int SRC = j / 2;
        localparam bit INVERT = (j % 2) == 1;

        always_ff @(posedge clk_400) begin
            if (reset) begin
                out_vld[j] <= 1'b0;
            end else if (take[SRC]) begin
                out_vld[j] <= 1'b1;
            end else if (out_acks[j]) begin
                out_vld[j] <= 1'b0;
            end
        end

        // odd outputs carry the complement
        always_ff @(posedge clk_400) begin
            if (take[SRC]) begin
                out_data[j] <= INVERT ? ~in_streams[SRC].data : in_streams[SRC].data;
            end
        end

        assign out_streams[j].vld = out_vld[j];
        assign out_streams[j].data = out_data[j];

        // a pending word waits unchanged for the packetizer
        assert property (@(posedge clk_400) disable iff (reset)
                         out_vld[j] && !out_acks[j] |=> out_vld[j] && $stable(out_data[j]))
            else $error("output %0d changed before ack", j + 1);
    end

endmodule

`default_nettype wire

// File: logic/noc_pkg.sv
`default_nettype none

package noc_pkg;

    // full packet on the tree links
    localparam int PACKET_BITS = 49;

    // user word carried inside a packet
    localparam int PAYLOAD_BITS = 32;

    // routing field widths
    localparam int LEAF_BITS = 5;
    localparam int PORT_BITS = 4;
    localparam int ADDR_BITS = 7;

    // port 0 of every leaf is the configuration port
    localparam logic [PORT_BITS-1:0] CFG_PORT = '0;

    // on send, addr holds the source output port; on receive it is ignored
    typedef struct packed {
        logic                    vld;
        logic [LEAF_BITS-1:0]    dest_leaf;
        logic [PORT_BITS-1:0]    dest_port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } noc_packet_t;

endpackage

`default_nettype wire

// File: verif/leaf_i3o6_tb.sv
`default_nettype none
`timescale 1ns/10ps

module leaf_i3o6_tb;
    import noc_pkg::*;
    import leaf_pkg::*;

    localparam int LEAF_ID = 5;
    localparam int CLK_PERIOD = 100;
    localparam int BURST_WORDS = 8;
    localparam int MIX_WORDS = 3;
    localparam int HOLD_WORDS = 6;
    localparam int SENT_WORDS = NUM_IN_PORTS * (2 * BURST_WORDS + MIX_WORDS + HOLD_WORDS);
    localparam int WATCHDOG_CYCLES = SENT_WORDS * 20 + 2000;

    logic        clk_400;
    logic        reset;
    logic        resend;
    noc_packet_t din;
    noc_packet_t dout;

    integer      seed;
    int          value_errors;
    int          unexpected_errors;
    route_cfg_t  route_model [NUM_OUT_PORTS];
    noc_packet_t exp_q [NUM_OUT_PORTS][$];

    leaf_i3o6 #(
        .LEAF_ID   (LEAF_ID),
        .FIFO_DEPTH(8)
    ) dut_i (
        .clk_400                (clk_400),
        .reset                  (reset),
        .resend                 (resend),
        .din_leaf_bft2interface (din),
        .dout_leaf_interface2bft(dout)
    );

    initial begin
        clk_400 = 1'b0;
        forever #(CLK_PERIOD / 2) clk_400 = ~clk_400;
    end

    // odd ports carry the word, even ports its complement
    function automatic noc_packet_t expected_packet(input int port, input logic [31:0] word);
        noc_packet_t pkt;
        pkt.vld = 1'b1;
        pkt.dest_leaf = route_model[port-1].dest_leaf;
        pkt.dest_port = route_model[port-1].dest_port;
        pkt.addr = ADDR_BITS'(port);
        pkt.payload = (port % 2 == 0) ? ~word : word;
        return pkt;
    endfunction

    function automatic route_cfg_t make_cfg(input int out_port, input int leaf, input int port);
        route_cfg_t cfg;
        cfg.out_port = OUT_PORT_BITS'(out_port);
        cfg.dest_leaf = LEAF_BITS'(leaf);
        cfg.dest_port = PORT_BITS'(port);
        cfg.reserved = '0;
        return cfg;
    endfunction

    function automatic int pending_packets();
        int total;
        total = 0;
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            total += exp_q[k].size();
        end
        return total;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk_400);
            din <= '0;
        end
    endtask

    task automatic send_packet(input int leaf, input int port, input logic [31:0] payload);
        noc_packet_t pkt;
        pkt.vld = 1'b1;
        pkt.dest_leaf = LEAF_BITS'(leaf);
        pkt.dest_port = PORT_BITS'(port);
        pkt.addr = '0;
        pkt.payload = payload;
        @(posedge clk_400);
        din <= pkt;
    endtask

    task automatic set_route(input int port, input int variant);
        route_cfg_t cfg;
        cfg = make_cfg(port, port * 4 + variant * 3 + 1, port + variant * 6);
        send_packet(LEAF_ID, 0, cfg);
        route_model[port-1] = cfg;
    endtask

    task automatic program_routes(input int variant);
        for (int p = 1; p <= NUM_OUT_PORTS; p++) begin
            set_route(p, variant);
        end
        idle_cycles(4);
    endtask

    // input port p feeds output ports 2p-1 and 2p
    task automatic send_data(input int port);
        logic [31:0] word;
        word = $random(seed);
        send_packet(LEAF_ID, port, word);
        exp_q[2*port-2].push_back(expected_packet(2 * port - 1, word));
        exp_q[2*port-1].push_back(expected_packet(2 * port, word));
    endtask

    task automatic wait_drain();
        while (pending_packets() != 0) begin
            @(posedge clk_400);
        end
        idle_cycles(4);
    endtask

    task automatic check_field(input string name, input int port,
                               input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            value_errors++;
            $display("ERROR %0t: port %0d %s is %h, expected %h", $time, port, name, got, exp);
        end
    endtask

    task automatic report_counts();
        $display("errors: %0d wrong values, %0d unexpected packets, %0d missing packets",
                 value_errors, unexpected_errors, pending_packets());
    endtask

    // dout is sampled mid-cycle, away from the driving edge
    always @(negedge clk_400) begin : compare_proc
        noc_packet_t got;
        noc_packet_t exp;
        int          port;
        if (!reset) begin
            got = dout;
            assert (!resend || got == '0) else begin
                value_errors++;
                $display("ERROR %0t: dout is %h during resend", $time, got);
            end
            if (got.vld) begin
                port = int'(got.addr);
                if (port < 1 || port > NUM_OUT_PORTS) begin
                    unexpected_errors++;
                    $display("packet at %0t names source port %0d, which does not exist",
                             $time, port);
                end else begin
                    assert (exp_q[port-1].size() != 0) else begin
                        unexpected_errors++;
                        $display("packet at %0t from port %0d was not expected", $time, port);
                    end
                    if (exp_q[port-1].size() != 0) begin
                        exp = exp_q[port-1].pop_front();
                        check_field("dest_leaf", port, 32'(got.dest_leaf), 32'(exp.dest_leaf));
                        check_field("dest_port", port, 32'(got.dest_port), 32'(exp.dest_port));
                        check_field("payload", port, got.payload, exp.payload);
                    end
                end
            end else begin
                assert (got == '0) else begin
                    value_errors++;
                    $display("ERROR %0t: idle dout is %h, expected zero", $time, got);
                end
            end
        end
    end

    initial begin
        seed = 32'h9a1ffc37;
        value_errors = 0;
        unexpected_errors = 0;
        reset = 1'b1;
        resend = 1'b0;
        din = '0;
        for (int k = 0; k < NUM_OUT_PORTS; k++) begin
            route_model[k] = '0;
        end
        repeat (8) @(posedge clk_400);
        reset <= 1'b0;

        // quiet leaf, dout must stay zero
        idle_cycles(20);

        program_routes(0);
        // none of these may touch the table
        send_packet(LEAF_ID, 0, make_cfg(0, 31, 15));
        send_packet(LEAF_ID, 0, make_cfg(7, 31, 15));
        send_packet(LEAF_ID + 1, 0, make_cfg(2, 30, 14));
        idle_cycles(4);

        for (int w = 0; w < BURST_WORDS; w++) begin
            for (int p = 1; p <= NUM_IN_PORTS; p++) begin
                send_data(p);
            end
        end
        idle_cycles(1);
        wait_drain();

        // foreign leaf and unused ports mixed with real data
        for (int w = 0; w < MIX_WORDS; w++) begin
            send_packet(LEAF_ID + 2, 1, $random(seed));
            send_packet(LEAF_ID, 4 + w, $random(seed));
            send_packet(LEAF_ID, 15, $random(seed));
            for (int p = 1; p <= NUM_IN_PORTS; p++) begin
                send_data(p);
            end
        end
        idle_cycles(1);
        wait_drain();

        // resend raised in the middle of a burst
        for (int w = 0; w < HOLD_WORDS; w++) begin
            for (int p = 1; p <= NUM_IN_PORTS; p++) begin
                send_data(p);
            end
            if (w == 1) begin
                resend <= 1'b1;
            end
        end
        idle_cycles(30);
        resend <= 1'b0;
        wait_drain();

        // new routes apply to later words only
        program_routes(1);
        for (int w = 0; w < BURST_WORDS; w++) begin
            for (int p = 1; p <= NUM_IN_PORTS; p++) begin
                send_data(p);
            end
        end
        idle_cycles(1);
        wait_drain();
        idle_cycles(10);

        report_counts();
        if (value_errors + unexpected_errors + pending_packets() == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout after %0d cycles with %0d packets still outstanding",
                 WATCHDOG_CYCLES, pending_packets());
        report_counts();
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
